// ==== logic/kc_params.svh ====
`ifndef KC_PARAMS_SVH
`define KC_PARAMS_SVH

// key block words taken from the request
`define KC_KB_WORDS 14
// md5 block size in 32-bit words
`define KC_BLOCK_WORDS 16
// md5 steps per block
`define KC_MD5_ROUNDS 64
// aes-128 rounds after the initial key addition
`define KC_AES_ROUNDS 10
// key, digest and cipher block width
`define KC_KEY_W 128

`endif

// ==== logic/kc_types_pkg.sv ====
`include "kc_params.svh"

package kc_types_pkg;

    // one key candidate to check
    typedef struct packed {
        logic [`KC_KEY_W-1:0]       in_buf; // encrypted hash
        logic [`KC_KB_WORDS*32-1:0] kb;     // key block, word 0 in the low bits
    } kc_req_t;

    // outcome of one check
    typedef struct packed {
        logic [`KC_KEY_W-1:0] key;   // md5 digest of the key block
        logic                 valid; // digest encrypts to in_buf
    } kc_result_t;

    // write port into the md5 block buffer
    typedef struct packed {
        logic [3:0]  addr;  // word index
        logic [31:0] data;
        logic        write;
    } md5_wr_t;

endpackage

// ==== logic/crypto_pkg.sv ====
package crypto_pkg;

    // md5 sine table, one entry per step
    localparam logic [31:0] md5_k [64] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // left-rotate amounts per step
    localparam logic [4:0] md5_s [64] = '{
        5'd7, 5'd12, 5'd17, 5'd22, 5'd7, 5'd12, 5'd17, 5'd22,
        5'd7, 5'd12, 5'd17, 5'd22, 5'd7, 5'd12, 5'd17, 5'd22,
        5'd5, 5'd9, 5'd14, 5'd20, 5'd5, 5'd9, 5'd14, 5'd20,
        5'd5, 5'd9, 5'd14, 5'd20, 5'd5, 5'd9, 5'd14, 5'd20,
        5'd4, 5'd11, 5'd16, 5'd23, 5'd4, 5'd11, 5'd16, 5'd23,
        5'd4, 5'd11, 5'd16, 5'd23, 5'd4, 5'd11, 5'd16, 5'd23,
        5'd6, 5'd10, 5'd15, 5'd21, 5'd6, 5'd10, 5'd15, 5'd21,
        5'd6, 5'd10, 5'd15, 5'd21, 5'd6, 5'd10, 5'd15, 5'd21
    };

    // a, b, c, d initial words
    localparam logic [31:0] md5_iv [4] = '{
        32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476
    };

    localparam logic [7:0] aes_rcon [10] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // forward s-box, entry 0 in the top byte
    localparam logic [2047:0] sbox_tab = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] aes_sbox(input logic [7:0] x);
        return sbox_tab[(255 - int'(x)) * 8 +: 8];
    endfunction

endpackage

// ==== logic/md5_core.sv ====
`timescale 1ns/100ps
`include "kc_params.svh"

module md5_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  kc_types_pkg::md5_wr_t   wr,
    input  logic                    start,
    output logic                    done,
    output logic [`KC_KEY_W-1:0]    digest
);

    localparam int RND_W = $clog2(`KC_MD5_ROUNDS);
    localparam logic [RND_W-1:0] LAST = RND_W'(`KC_MD5_ROUNDS - 1);

    logic [31:0]      blk [`KC_BLOCK_WORDS]; // message block buffer
    logic [31:0]      a, b, c, d;
    logic [RND_W-1:0] rnd;                   // next step index
    logic             busy;
    logic             fin;                   // final addition due
    logic [31:0]      sa, sb, sc, sd;        // step inputs
    logic [RND_W-1:0] idx;
    logic [31:0]      f;
    logic [3:0]       g;                     // message word index
    logic [31:0]      tmp;

    function automatic logic [31:0] rotl(input logic [31:0] x, input logic [4:0] s);
        return (x << s) | (x >> (6'd32 - {1'b0, s}));
    endfunction

    function automatic logic [31:0] bswap(input logic [31:0] x);
        return {x[7:0], x[15:8], x[23:16], x[31:24]};
    endfunction

    // step 0 runs on the start edge straight from the iv
    always_comb begin
        if (start) begin
            sa  = crypto_pkg::md5_iv[0];
            sb  = crypto_pkg::md5_iv[1];
            sc  = crypto_pkg::md5_iv[2];
            sd  = crypto_pkg::md5_iv[3];
            idx = '0;
        end else begin
            sa  = a;
            sb  = b;
            sc  = c;
            sd  = d;
            idx = rnd;
        end
        case (idx[5:4])
            2'd0: begin
                f = (sb & sc) | (~sb & sd);
                g = idx[3:0];
            end
            2'd1: begin
                f = (sd & sb) | (~sd & sc);
                g = idx[3:0] * 4'd5 + 4'd1;
            end
            2'd2: begin
                f = sb ^ sc ^ sd;
                g = idx[3:0] * 4'd3 + 4'd5;
            end
            default: begin
                f = sc ^ (sb | ~sd);
                g = idx[3:0] * 4'd7;
            end
        endcase
        tmp = sa + f + crypto_pkg::md5_k[idx] + blk[g];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            fin  <= 1'b0;
            done <= 1'b0;
            rnd  <= '0;
        end else if (!stall) begin
            done <= fin;
            fin  <= !start && busy && (rnd == LAST);
            if (start) begin
                busy <= 1'b1;
                rnd  <= RND_W'(1);
            end else if (busy) begin
                rnd <= rnd + 1'b1;
                if (rnd == LAST)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (wr.write)
                blk[wr.addr] <= wr.data;
            if (start || busy) begin
                a <= sd;
                d <= sc;
                c <= sb;
                b <= sb + rotl(tmp, crypto_pkg::md5_s[idx]);
            end
            if (fin) begin  // add the iv, bytes of each word little-endian
                digest <= {bswap(crypto_pkg::md5_iv[0] + a), bswap(crypto_pkg::md5_iv[1] + b),
                           bswap(crypto_pkg::md5_iv[2] + c), bswap(crypto_pkg::md5_iv[3] + d)};
            end
        end
    end

endmodule

// ==== logic/aes_enc_core.sv ====
`timescale 1ns/100ps
`include "kc_params.svh"

module aes_enc_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  start,
    input  logic [`KC_KEY_W-1:0]  key,
    input  logic [`KC_KEY_W-1:0]  block,
    output logic                  done,
    output logic [`KC_KEY_W-1:0]  cipher
);

    localparam logic [3:0] LAST = 4'(`KC_AES_ROUNDS - 1);

    logic [`KC_KEY_W-1:0] st;      // cipher state
    logic [`KC_KEY_W-1:0] rk;      // current round key
    logic [`KC_KEY_W-1:0] rk_nxt;
    logic [`KC_KEY_W-1:0] ss;      // after subbytes and shiftrows
    logic [3:0]           rnd;     // rounds completed
    logic                 busy;
    logic                 last;

    // byte n sits at [127-8n], column c holds bytes 4c..4c+3
    function automatic logic [127:0] sub_shift(input logic [127:0] s);
        logic [127:0] o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o[127 - 8 * (4 * c + r) -: 8] =
                    crypto_pkg::aes_sbox(s[127 - 8 * (4 * ((c + r) % 4) + r) -: 8]);
            end
        end
        return o;
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] x);
        return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [127:0] mix_cols(input logic [127:0] s);
        logic [127:0] o;
        logic [7:0]   b0, b1, b2, b3;
        for (int c = 0; c < 4; c++) begin
            {b0, b1, b2, b3} = s[127 - 32 * c -: 32];
            o[127 - 32 * c -: 32] = {xtime(b0) ^ xtime(b1) ^ b1 ^ b2 ^ b3,
                                     b0 ^ xtime(b1) ^ xtime(b2) ^ b2 ^ b3,
                                     b0 ^ b1 ^ xtime(b2) ^ xtime(b3) ^ b3,
                                     xtime(b0) ^ b0 ^ b1 ^ b2 ^ xtime(b3)};
        end
        return o;
    endfunction

    function automatic logic [127:0] next_key(input logic [127:0] k, input logic [7:0] rc);
        logic [31:0] t, w0, w1, w2, w3;
        t  = {k[23:0], k[31:24]};  // rotword
        t  = {crypto_pkg::aes_sbox(t[31:24]), crypto_pkg::aes_sbox(t[23:16]),
              crypto_pkg::aes_sbox(t[15:8]), crypto_pkg::aes_sbox(t[7:0])} ^ {rc, 24'h0};
        w0 = k[127:96] ^ t;
        w1 = k[95:64] ^ w0;
        w2 = k[63:32] ^ w1;
        w3 = k[31:0] ^ w2;
        return {w0, w1, w2, w3};
    endfunction

    assign last   = (rnd == LAST);
    assign rk_nxt = next_key(rk, crypto_pkg::aes_rcon[rnd]);
    assign ss     = sub_shift(st);
    assign cipher = st;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            rnd  <= '0;
        end else if (!stall) begin
            done <= !start && busy && last;
            if (start) begin
                busy <= 1'b1;
                rnd  <= '0;
            end else if (busy) begin
                rnd <= last ? 4'd0 : rnd + 4'd1;
                if (last)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (start) begin  // initial key addition
                st <= block ^ key;
                rk <= key;
            end else if (busy) begin
                st <= (last ? ss : mix_cols(ss)) ^ rk_nxt;  // no mixcolumns in round 10
                rk <= rk_nxt;
            end
        end
    end

endmodule

// ==== logic/kc_ctrl.sv ====
`timescale 1ns/100ps
`include "kc_params.svh"

module kc_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        start,
    input  kc_types_pkg::kc_req_t       req,
    output kc_types_pkg::md5_wr_t       md5_wr,
    output logic                        md5_start,
    input  logic                        md5_done,
    input  logic [`KC_KEY_W-1:0]        digest,
    output logic                        aes_start,
    output logic [`KC_KEY_W-1:0]        aes_key,
    output logic [`KC_KEY_W-1:0]        aes_block,
    input  logic                        aes_done,
    input  logic [`KC_KEY_W-1:0]        cipher,
    output kc_types_pkg::kc_result_t    result,
    output logic                        done
);

    localparam logic [31:0] MARKER    = 32'h8000_0000;  // single marker bit
    localparam logic [3:0]  LAST_WORD = 4'(`KC_BLOCK_WORDS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_HASH,
        S_ENC,
        S_REPORT
    } state_t;

    state_t                 state;
    logic [3:0]             cnt;    // block word index
    kc_types_pkg::kc_req_t  req_q;  // captured request
    logic [`KC_KEY_W-1:0]   dig_q;  // captured digest

    // block words: key block, then a zero word, then the marker
    always_comb begin
        md5_wr.write = (state == S_LOAD);
        md5_wr.addr  = cnt;
        if (cnt < `KC_KB_WORDS)
            md5_wr.data = req_q.kb[32 * cnt +: 32];
        else if (cnt == LAST_WORD)
            md5_wr.data = MARKER;
        else
            md5_wr.data = 32'h0;
    end

    assign aes_key   = dig_q;
    assign aes_block = dig_q;  // digest encrypted under itself

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cnt       <= '0;
            md5_start <= 1'b0;
            aes_start <= 1'b0;
            done      <= 1'b0;
            result    <= '0;
        end else if (!stall) begin
            md5_start <= 1'b0;
            aes_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_LOAD;
                        cnt   <= '0;
                    end
                end
                S_LOAD: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == LAST_WORD) begin  // buffer full, kick off hash
                        state     <= S_HASH;
                        md5_start <= 1'b1;
                    end
                end
                S_HASH: begin
                    if (md5_done) begin
                        state     <= S_ENC;
                        aes_start <= 1'b1;
                    end
                end
                S_ENC: begin
                    if (aes_done) begin
                        state        <= S_REPORT;
                        result.key   <= dig_q;
                        result.valid <= (cipher == req_q.in_buf);
                        done         <= 1'b1;
                    end
                end
                default: state <= S_IDLE;  // report, done is up this cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == S_IDLE && start)
                req_q <= req;
            if (state == S_HASH && md5_done)
                dig_q <= digest;
        end
    end

endmodule

// ==== logic/key_check_top.sv ====
`timescale 1ns/100ps
`include "kc_params.svh"

module key_check_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        start,
    input  kc_types_pkg::kc_req_t       req,
    output kc_types_pkg::kc_result_t    result,
    output logic                        done
);

    kc_types_pkg::md5_wr_t  md5_wr;
    logic                   md5_start;
    logic                   md5_done;
    logic [`KC_KEY_W-1:0]   digest;
    logic                   aes_start;
    logic                   aes_done;
    logic [`KC_KEY_W-1:0]   aes_key;
    logic [`KC_KEY_W-1:0]   aes_block;
    logic [`KC_KEY_W-1:0]   cipher;

    kc_ctrl u_ctrl (
        .clk, .rst, .stall, .start, .req,
        .md5_wr, .md5_start, .md5_done, .digest,
        .aes_start, .aes_key, .aes_block, .aes_done, .cipher,
        .result, .done
    );

    md5_core u_md5 (
        .clk, .rst, .stall,
        .wr     (md5_wr),
        .start  (md5_start),
        .done   (md5_done),
        .digest (digest)
    );

    aes_enc_core u_aes (
        .clk, .rst, .stall,
        .start  (aes_start),
        .key    (aes_key),
        .block  (aes_block),
        .done   (aes_done),
        .cipher (cipher)
    );

endmodule

// ==== verif/kc_assertions.sv ====
`timescale 1ns/100ps

module kc_assertions (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        start,
    input  logic [2:0]                  state,
    input  logic                        md5_start,
    input  logic                        aes_start,
    input  logic                        done,
    input  kc_types_pkg::kc_result_t    result
);

    localparam int LATENCY = 94;  // edges from start sample to done set

    logic track = 1'b0;  // job running with no stall so far
    int   age = 0;

    always @(posedge clk) begin
        if (rst) begin
            track <= 1'b0;
        end else if (!stall && start && state == 3'd0) begin
            track <= 1'b1;
            age   <= 0;
        end else if (track) begin
            if (stall || done)
                track <= 1'b0;
            else
                age <= age + 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) done && !stall |=> !done)
        else $error("done high for two cycles");

    assert property (@(posedge clk) disable iff (rst) md5_start && !stall |=> !md5_start)
        else $error("md5_start longer than one cycle");

    assert property (@(posedge clk) disable iff (rst) aes_start && !stall |=> !aes_start)
        else $error("aes_start longer than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(result) && $stable(done) && $stable(state)
                  && $stable(md5_start) && $stable(aes_start))
        else $error("controller outputs moved during stall");

    assert property (@(posedge clk) disable iff (rst) track && age < LATENCY |-> !done)
        else $error("done came early");

    assert property (@(posedge clk) disable iff (rst) track && age == LATENCY |-> done)
        else $error("done missing at the expected latency");

endmodule

bind kc_ctrl kc_assertions u_assert (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .start     (start),
    .state     (state),
    .md5_start (md5_start),
    .aes_start (aes_start),
    .done      (done),
    .result    (result)
);

// ==== verif/kc_ref.svh ====
function automatic logic [31:0] ref_rotl(input logic [31:0] x, input int n);
    return (x << n) | (x >> (32 - n));
endfunction

function automatic logic [31:0] ref_bswap(input logic [31:0] x);
    return {x[7:0], x[15:8], x[23:16], x[31:24]};
endfunction

// floor(abs(sin(i + 1)) * 2^32)
function automatic logic [31:0] md5_sine(input int i);
    real v;
    v = $sin(real'(i + 1));
    if (v < 0.0)
        v = -v;
    return 32'(longint'($floor(v * 4294967296.0)));
endfunction

function automatic int md5_shift(input int i);
    logic [19:0] row;  // four 5-bit amounts with the first one lowest
    case (i / 16)
        0:       row = {5'd22, 5'd17, 5'd12, 5'd7};
        1:       row = {5'd20, 5'd14, 5'd9, 5'd5};
        2:       row = {5'd23, 5'd16, 5'd11, 5'd4};
        default: row = {5'd21, 5'd15, 5'd10, 5'd6};
    endcase
    return int'(row[5 * (i % 4) +: 5]);
endfunction

function automatic logic [127:0] md5_ref(input logic [`KC_KB_WORDS*32-1:0] kb);
    logic [31:0] m [16];
    logic [31:0] a, b, c, d, f, t;
    int          g;
    for (int i = 0; i < `KC_KB_WORDS; i++)
        m[i] = kb[32 * i +: 32];
    m[14] = 32'h0;
    m[15] = 32'h8000_0000;  // marker bit and no length
    a = 32'h67452301;
    b = 32'hefcdab89;
    c = 32'h98badcfe;
    d = 32'h10325476;
    for (int i = 0; i < 64; i++) begin
        case (i / 16)
            0: begin
                f = (b & c) | (~b & d);
                g = i;
            end
            1: begin
                f = (d & b) | (~d & c);
                g = (5 * i + 1) % 16;
            end
            2: begin
                f = b ^ c ^ d;
                g = (3 * i + 5) % 16;
            end
            default: begin
                f = c ^ (b | ~d);
                g = (7 * i) % 16;
            end
        endcase
        t = d;
        d = c;
        c = b;
        b = b + ref_rotl(a + f + md5_sine(i) + m[g], md5_shift(i));
        a = t;
    end
    return {ref_bswap(a + 32'h67452301), ref_bswap(b + 32'hefcdab89),
            ref_bswap(c + 32'h98badcfe), ref_bswap(d + 32'h10325476)};
endfunction

function automatic logic [7:0] gf_mul(input logic [7:0] x, input logic [7:0] y);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 0; i < 8; i++) begin
        if (y[i])
            p = p ^ x;
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// field inverse then the affine map
function automatic logic [7:0] sbox_ref(input logic [7:0] x);
    logic [7:0] inv;
    inv = 8'h01;
    for (int i = 7; i >= 0; i--) begin  // x^254
        inv = gf_mul(inv, inv);
        if (i != 0)
            inv = gf_mul(inv, x);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
         ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic logic [127:0] aes_ref(input logic [127:0] key, input logic [127:0] pt);
    logic [31:0]  w [44];
    logic [7:0]   st [16];
    logic [7:0]   sh [16];
    logic [31:0]  t;
    logic [7:0]   rc, s0, s1, s2, s3;
    logic [127:0] ct;
    rc = 8'h01;
    for (int i = 0; i < 4; i++)
        w[i] = key[127 - 32 * i -: 32];
    for (int i = 4; i < 44; i++) begin
        t = w[i - 1];
        if (i % 4 == 0) begin
            t = {sbox_ref(t[23:16]), sbox_ref(t[15:8]), sbox_ref(t[7:0]),
                 sbox_ref(t[31:24])} ^ {rc, 24'h0};
            rc = gf_mul(rc, 8'h02);
        end
        w[i] = w[i - 4] ^ t;
    end
    for (int n = 0; n < 16; n++) begin
        t = w[n / 4];
        st[n] = pt[127 - 8 * n -: 8] ^ t[31 - 8 * (n % 4) -: 8];
    end
    for (int r = 1; r <= 10; r++) begin
        for (int n = 0; n < 16; n++)  // row n%4 rotates left by its index
            sh[n] = sbox_ref(st[4 * (((n / 4) + (n % 4)) % 4) + n % 4]);
        for (int c = 0; c < 4; c++) begin
            s0 = sh[4 * c];
            s1 = sh[4 * c + 1];
            s2 = sh[4 * c + 2];
            s3 = sh[4 * c + 3];
            if (r < 10) begin
                st[4 * c]     = gf_mul(s0, 8'h02) ^ gf_mul(s1, 8'h03) ^ s2 ^ s3;
                st[4 * c + 1] = s0 ^ gf_mul(s1, 8'h02) ^ gf_mul(s2, 8'h03) ^ s3;
                st[4 * c + 2] = s0 ^ s1 ^ gf_mul(s2, 8'h02) ^ gf_mul(s3, 8'h03);
                st[4 * c + 3] = gf_mul(s0, 8'h03) ^ s1 ^ s2 ^ gf_mul(s3, 8'h02);
            end else begin
                st[4 * c]     = s0;
                st[4 * c + 1] = s1;
                st[4 * c + 2] = s2;
                st[4 * c + 3] = s3;
            end
            t = w[4 * r + c];
            for (int k = 0; k < 4; k++)
                st[4 * c + k] = st[4 * c + k] ^ t[31 - 8 * k -: 8];
        end
    end
    for (int n = 0; n < 16; n++)
        ct[127 - 8 * n -: 8] = st[n];
    return ct;
endfunction

// ==== verif/kc_checker.sv ====
`timescale 1ns/100ps
`include "kc_params.svh"

module kc_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        start,
    input  kc_types_pkg::kc_req_t       req,
    input  logic                        done,
    input  kc_types_pkg::kc_result_t    result,
    output int                          pass_cnt,
    output int                          fail_cnt
);

    localparam int MAX_AGE = 200;  // unstalled cycles a job may take

    logic                   busy = 1'b0;
    kc_types_pkg::kc_req_t  req_q;
    int                     job_id = 0;
    int                     age = 0;
    int                     passes = 0;
    int                     fails = 0;

    `include "kc_ref.svh"

    assign pass_cnt = passes;
    assign fail_cnt = fails;

    always @(posedge clk) begin : compare
        logic [127:0] exp_key;
        logic         exp_valid;
        if (rst) begin
            busy = 1'b0;
        end else if (!stall) begin
            if (done) begin  // report cycle, a start here is dropped
                if (!busy) begin
                    $display("done pulse seen with no request pending");
                    fails++;
                end else begin
                    exp_key   = md5_ref(req_q.kb);
                    exp_valid = (aes_ref(exp_key, exp_key) == req_q.in_buf);
                    if (result.key === exp_key && result.valid === exp_valid) begin
                        $display("job%0d ok: key %h valid %b", job_id, exp_key, exp_valid);
                        passes++;
                    end else begin
                        $display("Error job%0d: expected key %h valid %b, actual key %h valid %b",
                                 job_id, exp_key, exp_valid, result.key, result.valid);
                        fails++;
                    end
                    busy = 1'b0;
                end
            end else if (start && !busy) begin
                req_q  = req;
                busy   = 1'b1;
                age    = 0;
                job_id++;
            end else if (busy) begin
                age++;
                if (age > MAX_AGE) begin
                    $display("job%0d was accepted but never completed", job_id);
                    fails++;
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

// ==== verif/kc_tb.sv ====
`timescale 1ns/100ps
`include "kc_params.svh"

module kc_tb;

    localparam int N_VEC      = 4;
    localparam int JOB_CYCLES = 300;
    localparam int MAX_JOBS   = 40;
    localparam int LIMIT      = MAX_JOBS * JOB_CYCLES;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic                       stall = 1'b0;
    logic                       start = 1'b0;
    kc_types_pkg::kc_req_t      req = '0;
    kc_types_pkg::kc_result_t   result;
    logic                       done;
    logic                       stall_mode = 1'b0;  // random stall on/off
    logic [`KC_KB_WORDS*32-1:0] vec_kb [N_VEC];
    int                         cycles = 0;
    int                         jobs = 0;
    int                         tb_errors = 0;
    int                         pass_cnt;
    int                         fail_cnt;

    `include "kc_ref.svh"

    key_check_top u_dut (
        .clk, .rst, .stall, .start, .req, .result, .done
    );

    kc_checker u_chk (
        .clk, .rst, .stall, .start, .req, .done, .result, .pass_cnt, .fail_cnt
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        logic mode;
        mode = stall_mode;  // mode as of this edge
        #0.5;
        stall = mode && (($urandom % 4) == 0);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("run hung: no finish after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // hold start until an unstalled edge takes it
    task automatic send(input logic [`KC_KB_WORDS*32-1:0] kb, input logic [127:0] in_buf);
        req.kb     = kb;
        req.in_buf = in_buf;
        start      = 1'b1;
        do
            @(posedge clk);
        while (stall);
        #0.5;
        start = 1'b0;
        jobs++;
    endtask

    task automatic wait_done();
        do
            @(posedge clk);
        while (!(done && !stall));
        #0.5;
    endtask

    task automatic run_job(input logic [`KC_KB_WORDS*32-1:0] kb, input logic flip,
                           input logic stalls);
        logic [127:0] key;
        logic [127:0] ct;
        stall_mode = stalls;
        key = md5_ref(kb);
        ct  = aes_ref(key, key);
        if (flip)
            ct = ct ^ (128'b1 << ($urandom % 128));  // one wrong bit
        send(kb, ct);
        wait_done();
        stall_mode = 1'b0;
    endtask

    initial begin
        int total_fail;
        void'($urandom(32'h821));
        $readmemh("verif/kc_vectors.hex", vec_kb);
        repeat (8) @(posedge clk);
        #0.5;
        rst = 1'b0;

        repeat (10) begin
            @(posedge clk);
            if (tb_errors == 0 && (done !== 1'b0 || result !== '0)) begin
                $display("Error reset: expected done 0 result %h, actual done %b result %h",
                         129'h0, done, result);
                tb_errors++;
            end
        end
        #0.5;
        if (tb_errors == 0)
            $display("reset ok: done low and result zero");

        for (int v = 0; v < N_VEC; v++) begin
            run_job(vec_kb[v], 1'b0, 1'b0);
            run_job(vec_kb[v], 1'b1, 1'b0);
        end
        for (int v = 0; v < N_VEC; v++) begin
            run_job(vec_kb[v], 1'b0, 1'b1);
            run_job(vec_kb[v], 1'b1, 1'b1);
        end

        // second start lands while busy and must be dropped
        send(vec_kb[0], aes_ref(md5_ref(vec_kb[0]), md5_ref(vec_kb[0])));
        repeat (20) @(posedge clk);
        #0.5;
        req.kb = vec_kb[1];
        start  = 1'b1;
        @(posedge clk);
        #0.5;
        start = 1'b0;
        wait_done();
        run_job(vec_kb[2], 1'b0, 1'b0);
        repeat (120) @(posedge clk);  // room for a stray done

        total_fail = fail_cnt + tb_errors;
        if (pass_cnt + fail_cnt != jobs) begin
            $display("%0d jobs were issued but %0d results came back", jobs,
                     pass_cnt + fail_cnt);
            total_fail++;
        end
        $display("tests passed %0d, failed %0d", pass_cnt, total_fail);
        if (total_fail == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verif/kc_vectors.hex ====
// one key block per line, 14 words of 32 bits
// word 13 on the left, word 0 on the right
0000000d_0000000c_0000000b_0000000a_00000009_00000008_00000007_00000006_00000005_00000004_00000003_00000002_00000001_00000000
deadbeef_cafef00d_01234567_89abcdef_fedcba98_76543210_0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0_13579bdf_2468ace0_a5a5a5a5_5a5a5a5a
ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff
80000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000_00000000

// ==== files.f ====
+incdir+logic
+incdir+verif
logic/kc_types_pkg.sv
logic/crypto_pkg.sv
logic/md5_core.sv
logic/aes_enc_core.sv
logic/kc_ctrl.sv
logic/key_check_top.sv
verif/kc_assertions.sv
verif/kc_checker.sv
verif/kc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the key check testbench, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module kc_tb -f files.f -o kc_sim \
    > build.log 2>&1 \
    && ./obj_dir/kc_sim > sim.log 2>&1
grep -qx "SIMULATION PASSED" sim.log 2>/dev/null \
    && echo "kc_tb run ok" \
    || { echo "kc_tb run failed, see build.log and sim.log"; exit 1; }
